//--- filelist.f
+incdir+test
source/fetch_pkg.sv
source/line_memory.sv
source/icache.sv
source/fetch_stage.sv
source/control_decoder.sv
source/fetch_decode_top.sv
test/tb_fetch_decode.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the fetch/decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_fetch_decode \
  -f filelist.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- source/control_decoder.sv
// ====================
// Control decoder
// Major opcode to registered control bundle
// ====================

module control_decoder
  import fetch_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     fetch_valid,
  input  word_t    fetch_pc,
  input  word_t    fetch_instr,
  output decoded_t dec_out
);

  opcode_e op;
  ctrl_t   ctrl_next;

  logic  valid_q;
  word_t pc_q;
  word_t instr_q;
  ctrl_t ctrl_q;

  assign op = opcode_e'(fetch_instr[6:0]);

  // Decode table
  always_comb
  begin
    ctrl_next        = '0;
    ctrl_next.alu_op = alu_add;
    case (op)
      op_lui:
      begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.alu_src   = 1'b1;
        ctrl_next.alu_op    = alu_pass;
      end
      op_auipc:
      begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.alu_src   = 1'b1;
      end
      op_jal:
      begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.jump      = 1'b1;
      end
      op_jalr:
      begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.jump      = 1'b1;
        ctrl_next.alu_src   = 1'b1;
      end
      op_branch:
      begin
        ctrl_next.branch = 1'b1;
        ctrl_next.alu_op = alu_sub_cmp;
      end
      op_load:
      begin
        ctrl_next.reg_write  = 1'b1;
        ctrl_next.mem_read   = 1'b1;
        ctrl_next.mem_to_reg = 1'b1;
        ctrl_next.alu_src    = 1'b1;
      end
      op_store:
      begin
        ctrl_next.mem_write = 1'b1;
        ctrl_next.alu_src   = 1'b1;
      end
      op_imm:
      begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.alu_src   = 1'b1;
        ctrl_next.alu_op    = alu_func;
      end
      op_reg:
      begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.alu_op    = alu_func;
      end
      // Unknown opcode, flag only
      default: ctrl_next.illegal = 1'b1;
    endcase
  end

  // Valid pulse
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= fetch_valid;
    end
  end

  // Payload follows the fetch register
  always_ff @(posedge clk)
  begin
    if (fetch_valid)
    begin
      pc_q    <= fetch_pc;
      instr_q <= fetch_instr;
      ctrl_q  <= ctrl_next;
    end
  end

  assign dec_out = '{valid: valid_q, pc: pc_q, instr: instr_q, ctrl: ctrl_q};

endmodule

//--- source/fetch_decode_top.sv
// ====================
// Instruction front end top
// Memory, cache, fetch stage and decoder
// ====================

module fetch_decode_top
  import fetch_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int CACHE_LINES = 8,
  parameter int MEM_LATENCY = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     load_valid,
  input  word_t    load_addr,
  input  word_t    load_word,
  input  logic     fetch_enable,
  output decoded_t dec_out
);

  // Fetch stage and cache
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;

  // Cache and memory
  mem_req_t mem_req;
  logic     mem_ready;
  line_t    mem_line;

  // Fetch register into decoder
  logic  fetch_valid;
  word_t fetch_pc;
  word_t fetch_instr;

  line_memory #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) line_memory_inst (
    .clk        (clk),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_word  (load_word),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .mem_line   (mem_line)
  );

  icache #(
    .CACHE_LINES (CACHE_LINES)
  ) icache_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_line  (mem_line)
  );

  fetch_stage #(
    .MEM_WORDS (MEM_WORDS)
  ) fetch_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_enable (fetch_enable),
    .fetch_req    (fetch_req),
    .fetch_rsp    (fetch_rsp),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr)
  );

  control_decoder control_decoder_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .dec_out     (dec_out)
  );

endmodule

//--- source/fetch_pkg.sv
// ====================
// Fetch/decode shared definitions
// Word and line types, opcode and ALU enums, control bundle
// and the request/response structs between the blocks
// ====================

package fetch_pkg;

  // Basic widths
  localparam int WORD_BITS        = 32;
  localparam int LINE_WORDS       = 4;
  localparam int LINE_BITS        = LINE_WORDS * WORD_BITS;
  // Byte offset inside a word, word offset inside a line
  localparam int BYTE_OFFSET_BITS = 2;
  localparam int LINE_OFFSET_BITS = $clog2(LINE_WORDS);
  localparam int LINE_BYTE_BITS   = LINE_OFFSET_BITS + BYTE_OFFSET_BITS;

  typedef logic [WORD_BITS-1:0] word_t;
  // Lowest address word sits in the low bits
  typedef logic [LINE_BITS-1:0] line_t;

  // RV32I major opcodes, other values are illegal
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add     = 2'b00,
    alu_sub_cmp = 2'b01,
    alu_func    = 2'b10,
    alu_pass    = 2'b11
  } alu_op_e;

  // 10-bit control bundle
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_to_reg;
    logic    mem_write;
    logic    alu_src;
    logic    branch;
    logic    jump;
    alu_op_e alu_op;
    logic    illegal;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
  } fetch_req_t;

  typedef struct packed {
    logic  done;
    word_t instr;
  } fetch_rsp_t;

  // Line address is the byte address shifted down by the line size
  typedef struct packed {
    logic  read;
    word_t line_addr;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
    ctrl_t ctrl;
  } decoded_t;

endpackage

//--- source/fetch_stage.sv
// ====================
// Fetch stage
// Program counter, request strobe and the fetch register
// holding each pc with its instruction word
// ====================

module fetch_stage
  import fetch_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       fetch_enable,
  output fetch_req_t fetch_req,
  input  fetch_rsp_t fetch_rsp,
  output logic       fetch_valid,
  output word_t      fetch_pc,
  output word_t      fetch_instr
);

  // Wrap mask for byte addresses, depth is a power of two
  localparam word_t PC_MASK = (word_t'(MEM_WORDS) << BYTE_OFFSET_BITS) - 1'b1;

  word_t pc;
  // Fetch outstanding in the cache
  logic  busy;
  logic  req_valid;
  word_t pc_next;

  // New request only when nothing is in flight
  assign req_valid = fetch_enable && !busy;
  assign fetch_req = '{valid: req_valid, pc: pc};

  // Sequential next pc with wrap at end of memory
  assign pc_next = (pc + word_t'(4)) & PC_MASK;

  // Pc, busy flag and valid pulse
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc          <= '0;
      busy        <= 1'b0;
      fetch_valid <= 1'b0;
    end
    else
    begin
      fetch_valid <= fetch_rsp.done;
      if (fetch_rsp.done)
      begin
        busy <= 1'b0;
        pc   <= pc_next;
      end
      else if (req_valid)
      begin
        busy <= 1'b1;
      end
    end
  end

  // Fetch register payload
  always_ff @(posedge clk)
  begin
    if (fetch_rsp.done)
    begin
      fetch_pc    <= pc;
      fetch_instr <= fetch_rsp.instr;
    end
  end

endmodule

//--- source/icache.sv
// ====================
// Direct-mapped instruction cache
// Valid, tag and data arrays with a blocking refill FSM,
// one outstanding fetch at a time
// ====================

module icache
  import fetch_pkg::*;
#(
  parameter int CACHE_LINES = 8
) (
  input  logic       clk,
  input  logic       arst_n,
  input  fetch_req_t fetch_req,
  output fetch_rsp_t fetch_rsp,
  output mem_req_t   mem_req,
  input  logic       mem_ready,
  input  line_t      mem_line
);

  localparam int INDEX_BITS = $clog2(CACHE_LINES);
  localparam int TAG_LSB    = LINE_BYTE_BITS + INDEX_BITS;
  localparam int TAG_BITS   = WORD_BITS - TAG_LSB;

  typedef enum logic [1:0] {
    idle,
    lookup,
    refill_issue,
    refill_wait
  } state_e;

  state_e state;

  // Registered copy of the request pc
  word_t req_pc;

  // Cache arrays
  line_t                 data_q  [CACHE_LINES];
  logic [TAG_BITS-1:0]   tag_q   [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;

  // Address fields of the held request
  logic [LINE_OFFSET_BITS-1:0] req_off;
  logic [INDEX_BITS-1:0]       req_idx;
  logic [TAG_BITS-1:0]         req_tag;

  logic  hit;
  line_t hit_line;
  logic  fill;

  assign req_off  = req_pc[BYTE_OFFSET_BITS +: LINE_OFFSET_BITS];
  assign req_idx  = req_pc[LINE_BYTE_BITS +: INDEX_BITS];
  assign req_tag  = req_pc[TAG_LSB +: TAG_BITS];
  assign hit_line = data_q[req_idx];
  assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  // Line arrives from memory
  assign fill = (state == refill_wait) && mem_ready;

  // Refill FSM
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= idle;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (fetch_req.valid)
          begin
            state <= lookup;
          end
        end
        // Hit returns here, miss goes to memory
        lookup:       state <= hit ? idle : refill_issue;
        refill_issue: state <= refill_wait;
        refill_wait:
        begin
          if (mem_ready)
          begin
            state <= idle;
          end
        end
        default:      state <= idle;
      endcase
    end
  end

  // Valid bits, all lines invalid after reset
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q <= '0;
    end
    else if (fill)
    begin
      valid_q[req_idx] <= 1'b1;
    end
  end

  // Request capture and line/tag write
  always_ff @(posedge clk)
  begin
    if ((state == idle) && fetch_req.valid)
    begin
      req_pc <= fetch_req.pc;
    end
    if (fill)
    begin
      data_q[req_idx] <= mem_line;
      tag_q[req_idx]  <= req_tag;
    end
  end

  // Single read strobe while issuing
  assign mem_req = '{read: (state == refill_issue),
                     line_addr: word_t'(req_pc >> LINE_BYTE_BITS)};

  // Done on a hit in lookup or when the refill line is in
  always_comb
  begin
    fetch_rsp.done  = 1'b0;
    fetch_rsp.instr = hit_line[req_off*WORD_BITS +: WORD_BITS];
    if (state == lookup)
    begin
      fetch_rsp.done = hit;
    end
    else if (fill)
    begin
      // Word straight from the incoming line
      fetch_rsp.done  = 1'b1;
      fetch_rsp.instr = mem_line[req_off*WORD_BITS +: WORD_BITS];
    end
  end

endmodule

//--- source/line_memory.sv
// ====================
// Main memory model
// Word-wide program load port, fixed-latency 128-bit line reads
// ====================

module line_memory
  import fetch_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 4
) (
  input  logic     clk,
  input  logic     load_valid,
  input  word_t    load_addr,
  input  word_t    load_word,
  input  mem_req_t mem_req,
  output logic     mem_ready,
  output line_t    mem_line
);

  localparam int ADDR_BITS     = $clog2(MEM_WORDS);
  localparam int LINE_IDX_BITS = ADDR_BITS - LINE_OFFSET_BITS;
  localparam int CNT_BITS      = $clog2(MEM_LATENCY + 1);

  // Storage, one word per entry
  word_t mem [MEM_WORDS];

  // Line being read and cycles left until it is presented
  logic [LINE_IDX_BITS-1:0] line_idx;
  logic [CNT_BITS-1:0]      cnt;

  // Program load, one word per cycle
  always_ff @(posedge clk)
  begin
    if (load_valid)
    begin
      mem[load_addr[ADDR_BITS-1:0]] <= load_word;
    end
  end

  // Latency counter
  // Loaded on the strobe, ready while it reads one
  always_ff @(posedge clk)
  begin
    if (mem_req.read)
    begin
      cnt      <= CNT_BITS'(MEM_LATENCY);
      line_idx <= mem_req.line_addr[LINE_IDX_BITS-1:0];
    end
    else if (cnt != '0)
    begin
      cnt <= cnt - 1'b1;
    end
  end

  assign mem_ready = (cnt == CNT_BITS'(1));

  // Gather the four aligned words of the line
  always_comb
  begin
    for (int k = 0; k < LINE_WORDS; k++)
    begin
      mem_line[k*WORD_BITS +: WORD_BITS] = mem[{line_idx, LINE_OFFSET_BITS'(k)}];
    end
  end

endmodule

//--- test/tb_fetch_model.svh
// ====================
// Reference model for the fetch/decode testbench
// Program image, expected pc sequence and decode table
// ====================

`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// ALU operation codes of the control bundle
localparam logic [1:0] ALU_ADD  = 2'd0;
localparam logic [1:0] ALU_SUB  = 2'd1;
localparam logic [1:0] ALU_FUNC = 2'd2;
localparam logic [1:0] ALU_PASS = 2'd3;

// Program image, one entry per memory word
logic [31:0] image [MEM_WORDS];
// Byte address of the next expected result
logic [31:0] exp_pc;

// Nine legal RV32I major opcodes and one illegal code
function automatic logic [6:0] opcode_choice(input int sel);
  case (sel)
    0:       opcode_choice = 7'b0110111;
    1:       opcode_choice = 7'b0010111;
    2:       opcode_choice = 7'b1101111;
    3:       opcode_choice = 7'b1100111;
    4:       opcode_choice = 7'b1100011;
    5:       opcode_choice = 7'b0000011;
    6:       opcode_choice = 7'b0100011;
    7:       opcode_choice = 7'b0010011;
    8:       opcode_choice = 7'b0110011;
    // Not a major opcode of the base set
    default: opcode_choice = 7'b1111111;
  endcase
endfunction

// Random upper bits over a random opcode for every word
task automatic fill_image(inout integer s);
  int          sel;
  logic [31:0] upper;
  for (int i = 0; i < MEM_WORDS; i++)
  begin
    sel      = {$random(s)} % 10;
    upper    = $random(s);
    image[i] = {upper[31:7], opcode_choice(sel)};
  end
endtask

// Order: reg_write mem_read mem_to_reg mem_write alu_src branch jump alu_op illegal
function automatic logic [9:0] expected_ctrl(input logic [31:0] instr);
  case (instr[6:0])
    7'b0110111: expected_ctrl = {7'b1000100, ALU_PASS, 1'b0};
    7'b0010111: expected_ctrl = {7'b1000100, ALU_ADD, 1'b0};
    7'b1101111: expected_ctrl = {7'b1000001, ALU_ADD, 1'b0};
    7'b1100111: expected_ctrl = {7'b1000101, ALU_ADD, 1'b0};
    7'b1100011: expected_ctrl = {7'b0000010, ALU_SUB, 1'b0};
    7'b0000011: expected_ctrl = {7'b1110100, ALU_ADD, 1'b0};
    7'b0100011: expected_ctrl = {7'b0001100, ALU_ADD, 1'b0};
    7'b0010011: expected_ctrl = {7'b1000100, ALU_FUNC, 1'b0};
    7'b0110011: expected_ctrl = {7'b1000000, ALU_FUNC, 1'b0};
    default:    expected_ctrl = {7'b0000000, ALU_ADD, 1'b1};
  endcase
endfunction

// Sequential pc, wraps at the end of memory
function automatic logic [31:0] next_pc(input logic [31:0] pc);
  next_pc = (pc + 32'd4) % (MEM_WORDS * 4);
endfunction

// Loaded word at a byte address
function automatic logic [31:0] word_at(input logic [31:0] pc);
  word_at = image[pc[ADDR_BITS+1:2]];
endfunction

`endif

//--- test/tb_fetch_decode.sv
// ====================
// Testbench for the instruction front end
// Random program load, three passes through memory with pauses,
// pc order, instruction and decode checks against a model
// ====================

module tb_fetch_decode
  import fetch_pkg::*;
;

  localparam int MEM_WORDS   = 256;
  localparam int CACHE_LINES = 8;
  localparam int MEM_LATENCY = 4;
  localparam int ADDR_BITS   = $clog2(MEM_WORDS);
  localparam int PERIOD      = 100;

  // Three passes so that lines get evicted and refilled
  localparam int TOTAL     = 3 * MEM_WORDS;
  localparam int PAUSES    = 4;
  localparam int MAX_PAUSE = 40;
  // Per-result budget, then load and reset, then pauses
  localparam int TIMEOUT = TOTAL * (MEM_LATENCY + 6) * PERIOD
                         + (MEM_WORDS + 10) * PERIOD
                         + PAUSES * MAX_PAUSE * PERIOD;

  logic     clk;
  logic     arst_n;
  logic     load_valid;
  word_t    load_addr;
  word_t    load_word;
  logic     fetch_enable;
  decoded_t dec_out;

  integer seed;
  int     results;
  int     checks;
  int     errors;
  // High while no result may appear
  logic   idle_expected;

  `include "tb_fetch_model.svh"

  fetch_decode_top #(
    .MEM_WORDS   (MEM_WORDS),
    .CACHE_LINES (CACHE_LINES),
    .MEM_LATENCY (MEM_LATENCY)
  ) fetch_decode_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .load_valid   (load_valid),
    .load_addr    (load_addr),
    .load_word    (load_word),
    .fetch_enable (fetch_enable),
    .dec_out      (dec_out)
  );

  always #(PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h at time %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d results, %0d checks, %0d errors", results, checks, errors);
  endtask

  // Result monitor, sampled away from the rising edge
  always @(negedge clk)
  begin
    if (dec_out.valid)
    begin
      if (idle_expected)
      begin
        errors++;
        $display("Unexpected result for pc %h while the front end should be idle", dec_out.pc);
      end
      check_value("pc_order", exp_pc, dec_out.pc);
      check_value("instr", word_at(exp_pc), dec_out.instr);
      check_value("ctrl", 32'(expected_ctrl(word_at(exp_pc))), 32'(dec_out.ctrl));
      exp_pc = next_pc(exp_pc);
      results++;
    end
  end

  // Stimulus
  initial
  begin
    int pause_at;
    int pause_len;
    int count_at_stop;
    clk           = 1'b0;
    arst_n        = 1'b0;
    load_valid    = 1'b0;
    load_addr     = '0;
    load_word     = '0;
    fetch_enable  = 1'b0;
    seed          = 32'h8a74_3cb7;
    results       = 0;
    checks        = 0;
    errors        = 0;
    idle_expected = 1'b1;
    exp_pc        = '0;
    fill_image(seed);
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    // Program load with fetching disabled
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      @(posedge clk);
      load_valid <= 1'b1;
      load_addr  <= i;
      load_word  <= image[i];
    end
    @(posedge clk);
    load_valid <= 1'b0;
    repeat (2) @(posedge clk);
    idle_expected = 1'b0;
    fetch_enable <= 1'b1;
    // Pauses spread over the run
    for (int k = 1; k <= PAUSES; k++)
    begin
      pause_at  = k * TOTAL / (PAUSES + 1) + {$random(seed)} % 32;
      pause_len = 5 + {$random(seed)} % (MAX_PAUSE - 4);
      wait (results == pause_at);
      // Edge right after a result, one fetch in flight
      @(posedge clk);
      fetch_enable <= 1'b0;
      count_at_stop = results;
      repeat (pause_len) @(posedge clk);
      if (results - count_at_stop > 1)
      begin
        errors++;
        $display("%0d results arrived during a pause, at most one allowed",
                 results - count_at_stop);
      end
      fetch_enable <= 1'b1;
    end
    wait (results == TOTAL);
    @(posedge clk);
    fetch_enable <= 1'b0;
    repeat (MEM_LATENCY + 6) @(posedge clk);
    report_counts();
    if (errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT);
    $display("Watchdog expired with %0d of %0d results received", results, TOTAL);
    report_counts();
    $display("TEST FAIL");
    $finish;
  end

endmodule
